/* hw/rv_pkg.sv */
package rv_pkg;

  // datapath and address widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // unified memory geometry, word addressed
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  // first fetch address after run
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // major opcodes of the kept subset
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 values that must match
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;

  // funct7 for the register-register ops
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // ebreak is matched on the whole word
  localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

  // core state codes
  localparam int         ST_W     = 3;
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_FETCH = 3'd1;
  localparam logic [2:0] ST_IWAIT = 3'd2;
  localparam logic [2:0] ST_EXEC  = 3'd3;
  localparam logic [2:0] ST_DWAIT = 3'd4;
  localparam logic [2:0] ST_HALT  = 3'd5;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_e;

  // one instruction word, five views of the same bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } rv_inst_u;

endpackage

/* hw/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::rv_inst_u              inst,
  output logic [rv_pkg::REG_IDX_W-1:0]  rd,
  output logic [rv_pkg::REG_IDX_W-1:0]  rs1,
  output logic [rv_pkg::REG_IDX_W-1:0]  rs2,
  output logic [rv_pkg::XLEN-1:0]       imm,
  output rv_pkg::alu_op_e               alu_op,
  output logic                          use_imm,
  output logic                          use_pc,
  output logic                          is_load,
  output logic                          is_store,
  output logic                          is_branch,
  output logic                          reg_write,
  output logic                          is_ebreak,
  output logic                          illegal
);
  import rv_pkg::*;

  // register fields sit at the same bits in every format
  assign rd  = inst.r.rd;
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;

  // immediate picked by format
  always_comb begin
    case (inst.r.opcode)
      OP_STORE:
        imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      OP_BRANCH:
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      OP_LUI, OP_AUIPC:
        imm = {inst.u.imm_31_12, 12'h000};
      default:
        imm = {{20{inst.i.imm[11]}}, inst.i.imm};
    endcase
  end

  // class flags, anything off the legal list falls to illegal
  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    reg_write = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (inst.r.opcode)
      OP_REG: begin
        if (inst.r.funct3 == F3_ADD && inst.r.funct7 == F7_ADD) begin
          reg_write = 1'b1;
        end else if (inst.r.funct3 == F3_ADD && inst.r.funct7 == F7_SUB) begin
          alu_op    = ALU_SUB;
          reg_write = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_IMM: begin
        // addi only
        if (inst.i.funct3 == F3_ADD) begin
          use_imm   = 1'b1;
          reg_write = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_LUI: begin
        alu_op    = ALU_PASS_B;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OP_AUIPC: begin
        // pc plus upper immediate
        use_pc    = 1'b1;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LOAD: begin
        if (inst.i.funct3 == F3_LW) begin
          use_imm   = 1'b1;
          is_load   = 1'b1;
          reg_write = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_STORE: begin
        if (inst.s.funct3 == F3_SW) begin
          use_imm  = 1'b1;
          is_store = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_BRANCH: begin
        // beq compares through the subtractor
        if (inst.b.funct3 == F3_BEQ) begin
          alu_op    = ALU_SUB;
          is_branch = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OP_SYSTEM: begin
        if (inst == EBREAK_WORD) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::REG_IDX_W-1:0]  rs1,
  input  logic [rv_pkg::REG_IDX_W-1:0]  rs2,
  input  logic [rv_pkg::REG_IDX_W-1:0]  rd,
  input  logic                          we,
  input  logic [rv_pkg::XLEN-1:0]       wdata,
  output logic [rv_pkg::XLEN-1:0]       rdata1,
  output logic [rv_pkg::XLEN-1:0]       rdata2
);
  import rv_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs [1:(2**REG_IDX_W)-1];

  // writes to x0 dropped
  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, x0 reads as zero
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/rv_alu.sv */
`timescale 1ns/10ps

module rv_alu (
  input  logic [rv_pkg::XLEN-1:0]  a,
  input  logic [rv_pkg::XLEN-1:0]  b,
  input  rv_pkg::alu_op_e          op,
  output logic [rv_pkg::XLEN-1:0]  result,
  output logic                     zero
);
  import rv_pkg::*;

  always_comb begin
    case (op)
      ALU_SUB:    result = a - b;
      // lui passes the immediate straight through
      ALU_PASS_B: result = b;
      default:    result = a + b;
    endcase
  end

  // beq looks at this on the difference
  assign zero = (result == '0);

endmodule

/* hw/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [rv_pkg::XLEN-1:0]  mem_addr,
  output logic [rv_pkg::XLEN-1:0]  mem_wdata,
  input  logic                     mem_gnt,
  input  logic                     mem_rvalid,
  input  logic [rv_pkg::XLEN-1:0]  mem_rdata,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic                     halted,
  output logic                     trap
);
  import rv_pkg::*;

  logic [ST_W-1:0]      state;
  rv_inst_u             inst_q;

  logic [REG_IDX_W-1:0] rd;
  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic [XLEN-1:0]      imm;
  alu_op_e              alu_op;
  logic                 use_imm;
  logic                 use_pc;
  logic                 is_load;
  logic                 is_store;
  logic                 is_branch;
  logic                 reg_write;
  logic                 is_ebreak;
  logic                 illegal;

  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN-1:0]      op_a;
  logic [XLEN-1:0]      op_b;
  logic [XLEN-1:0]      alu_result;
  logic                 alu_zero;
  logic                 rf_we;
  logic [XLEN-1:0]      rf_wdata;
  logic [XLEN-1:0]      pc_seq;
  logic [XLEN-1:0]      pc_next;
  logic                 mem_op;

  rv_decoder u_decoder (
    .inst      (inst_q),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_branch (is_branch),
    .reg_write (reg_write),
    .is_ebreak (is_ebreak),
    .illegal   (illegal)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .we     (rf_we),
    .wdata  (rf_wdata),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // operand muxes
  assign op_a = use_pc ? pc : rs1_data;
  assign op_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // taken beq jumps by the b-format offset
  assign pc_seq  = pc + 32'd4;
  assign pc_next = (is_branch && alu_zero) ? pc + imm : pc_seq;
  assign mem_op  = is_load | is_store;

  // alu result in exec, load data when it returns
  assign rf_we    = (state == ST_EXEC && reg_write && !is_load) ||
                    (state == ST_DWAIT && mem_rvalid && reg_write);
  assign rf_wdata = (state == ST_DWAIT) ? mem_rdata : alu_result;

  // bus request straight from the state, held until granted
  always_comb begin
    mem_req   = 1'b0;
    mem_we    = 1'b0;
    mem_addr  = pc;
    mem_wdata = rs2_data;
    if (state == ST_FETCH) begin
      mem_req = 1'b1;
    end else if (state == ST_EXEC && mem_op) begin
      // lw and sw address is the alu sum
      mem_req  = 1'b1;
      mem_we   = is_store;
      mem_addr = alu_result;
    end
  end

  assign halted = (state == ST_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      pc    <= RESET_PC;
      trap  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (run) begin
            state <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          // host may hold us off here
          if (mem_gnt) begin
            state <= ST_IWAIT;
          end
        end
        ST_IWAIT: begin
          if (mem_rvalid) begin
            state <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (illegal) begin
            // pc stays on the bad word
            trap  <= 1'b1;
            state <= ST_HALT;
          end else if (is_ebreak) begin
            state <= ST_HALT;
          end else if (mem_op) begin
            if (mem_gnt && is_load) begin
              state <= ST_DWAIT;
            end else if (mem_gnt) begin
              pc    <= pc_seq;
              state <= ST_FETCH;
            end
          end else begin
            pc    <= pc_next;
            state <= ST_FETCH;
          end
        end
        ST_DWAIT: begin
          if (mem_rvalid) begin
            pc    <= pc_seq;
            state <= ST_FETCH;
          end
        end
        default: state <= ST_HALT;
      endcase
    end
  end

  // fetched word, no reset needed
  always_ff @(posedge clk) begin
    if (state == ST_IWAIT && mem_rvalid) begin
      inst_q <= mem_rdata;
    end
  end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       host_req,
  input  logic                       host_we,
  input  logic [rv_pkg::XLEN-1:0]    host_addr,
  input  logic [rv_pkg::XLEN-1:0]    host_wdata,
  output logic [rv_pkg::XLEN-1:0]    host_rdata,
  output logic                       host_rvalid,
  input  logic                       core_req,
  input  logic                       core_we,
  input  logic [rv_pkg::XLEN-1:0]    core_addr,
  input  logic [rv_pkg::XLEN-1:0]    core_wdata,
  output logic                       core_gnt,
  output logic                       core_rvalid,
  output logic [rv_pkg::XLEN-1:0]    core_rdata,
  output logic                       mem_en,
  output logic                       mem_we,
  output logic [rv_pkg::MEM_AW-1:0]  mem_addr,
  output logic [rv_pkg::XLEN-1:0]    mem_wdata,
  input  logic [rv_pkg::XLEN-1:0]    mem_rdata
);
  import rv_pkg::*;

  // read in flight, and whether the host issued it
  logic rd_pend;
  logic rd_host;

  // host always wins
  assign core_gnt = core_req & ~host_req;

  // winner onto the memory, byte address cut to a word index
  assign mem_en    = host_req | core_req;
  assign mem_we    = host_req ? host_we : core_we;
  assign mem_addr  = host_req ? host_addr[MEM_AW+1:2] : core_addr[MEM_AW+1:2];
  assign mem_wdata = host_req ? host_wdata : core_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
      rd_host <= 1'b0;
    end else begin
      rd_pend <= mem_en & ~mem_we;
      rd_host <= host_req;
    end
  end

  // one-cycle pulse to whoever owned the read
  assign host_rvalid = rd_pend & rd_host;
  assign core_rvalid = rd_pend & ~rd_host;
  assign host_rdata  = mem_rdata;
  assign core_rdata  = mem_rdata;

endmodule

/* hw/unified_mem.sv */
`timescale 1ns/10ps

module unified_mem (
  input  logic                       clk,
  input  logic                       en,
  input  logic                       we,
  input  logic [rv_pkg::MEM_AW-1:0]  addr,
  input  logic [rv_pkg::XLEN-1:0]    wdata,
  output logic [rv_pkg::XLEN-1:0]    rdata
);
  import rv_pkg::*;

  // code and data share this array
  logic [XLEN-1:0] mem [0:MEM_WORDS-1];

  // single port, read data one cycle later
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

/* hw/rv_soc.sv */
`timescale 1ns/10ps

module rv_soc (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic                     host_req,
  input  logic                     host_we,
  input  logic [rv_pkg::XLEN-1:0]  host_addr,
  input  logic [rv_pkg::XLEN-1:0]  host_wdata,
  output logic [rv_pkg::XLEN-1:0]  host_rdata,
  output logic                     host_rvalid,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic                     halted,
  output logic                     trap
);
  import rv_pkg::*;

  // core side of the arbiter
  logic              core_req;
  logic              core_we;
  logic [XLEN-1:0]   core_addr;
  logic [XLEN-1:0]   core_wdata;
  logic              core_gnt;
  logic              core_rvalid;
  logic [XLEN-1:0]   core_rdata;

  // memory side
  logic              mem_en;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_addr;
  logic [XLEN-1:0]   mem_wdata;
  logic [XLEN-1:0]   mem_rdata;

  rv_core u_core (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .mem_req    (core_req),
    .mem_we     (core_we),
    .mem_addr   (core_addr),
    .mem_wdata  (core_wdata),
    .mem_gnt    (core_gnt),
    .mem_rvalid (core_rvalid),
    .mem_rdata  (core_rdata),
    .pc         (pc),
    .halted     (halted),
    .trap       (trap)
  );

  mem_arbiter u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .core_req    (core_req),
    .core_we     (core_we),
    .core_addr   (core_addr),
    .core_wdata  (core_wdata),
    .core_gnt    (core_gnt),
    .core_rvalid (core_rvalid),
    .core_rdata  (core_rdata),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata)
  );

  unified_mem u_mem (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

/* verification/rv_soc_assert.sv */
`timescale 1ns/10ps

module rv_soc_assert (
  input logic                     clk,
  input logic                     rst,
  input logic                     host_req,
  input logic                     host_we,
  input logic                     host_rvalid,
  input logic                     core_req,
  input logic                     core_we,
  input logic [rv_pkg::XLEN-1:0]  core_addr,
  input logic                     halted
);

  // held off by the host, the core keeps its request steady
  core_held_off: assert property (@(posedge clk) disable iff (rst)
    (core_req && host_req) |=> (core_req && $stable(core_we) && $stable(core_addr)))
    else $error("core request changed while the host held the bus");

  // read data pulse exactly one cycle after a host read
  host_rvalid_after: assert property (@(posedge clk) disable iff (rst)
    (host_req && !host_we) |=> host_rvalid)
    else $error("host_rvalid missing after host read");

  host_rvalid_only: assert property (@(posedge clk) disable iff (rst)
    host_rvalid |-> $past(host_req && !host_we))
    else $error("host_rvalid without a host read the cycle before");

  // sticky until reset
  halted_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> (halted || rst))
    else $error("halted dropped without reset");

  halted_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> !core_req)
    else $error("core_req high while halted");

endmodule

bind rv_soc rv_soc_assert u_soc_assert (
  .clk         (clk),
  .rst         (rst),
  .host_req    (host_req),
  .host_we     (host_we),
  .host_rvalid (host_rvalid),
  .core_req    (core_req),
  .core_we     (core_we),
  .core_addr   (core_addr),
  .halted      (halted)
);

/* verification/rv_soc_tb.sv */
`timescale 1ns/10ps

module rv_soc_tb;
  import rv_pkg::*;

  // hard stop, far past the length of all tests
  localparam int MAX_CYCLES = 20000;
  localparam int HALT_LIMIT = 2000;
  localparam int SUM_N      = 8;
  localparam logic [31:0] ARITH_BASE = 32'h0000_0200;
  localparam logic [31:0] SUM_BASE   = 32'h0000_0300;

  logic            clk = 1'b0;
  logic            rst;
  logic            run;
  logic            host_req;
  logic            host_we;
  logic [XLEN-1:0] host_addr;
  logic [XLEN-1:0] host_wdata;
  logic [XLEN-1:0] host_rdata;
  logic            host_rvalid;
  logic [XLEN-1:0] pc;
  logic            halted;
  logic            trap;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // shadow of memory as the host wrote it
  logic [31:0] mem_model [0:MEM_WORDS-1];
  logic [31:0] prog [$];
  logic [31:0] arith_exp [0:4];
  logic [31:0] sum_exp;

  rv_soc dut0 (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .pc          (pc),
    .halted      (halted),
    .trap        (trap)
  );

  always #4 clk = ~clk;

  // global cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH time=%0t %s expected=%08h actual=%08h", $time, name, exp, act);
    end
  endtask

  // instruction encoders, fields in RV32I order
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  // byte offset, bit 0 dropped
  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  // fill value tied to every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[9:2], ~a[9:2], a[9:2] ^ 8'h5a, 8'hc3} ^ a;
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    rst <= 1'b1;
    run <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic start_core();
    @(posedge clk);
    run <= 1'b1;
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clk);
    host_req <= 1'b0;
    host_we  <= 1'b0;
    mem_model[addr[9:2]] = data;
  endtask

  task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
    int n;
    @(posedge clk);
    host_req  <= 1'b1;
    host_we   <= 1'b0;
    host_addr <= addr;
    @(posedge clk);
    host_req <= 1'b0;
    n = 0;
    // rvalid expected one cycle after the request
    do begin
      @(posedge clk);
      n++;
    end while (!host_rvalid && n < 4);
    if (!host_rvalid) begin
      errors++;
      $display("ERROR: no read data returned for address %08h", addr);
    end
    data = host_rdata;
  endtask

  task automatic load_program(input logic [31:0] base);
    logic [31:0] a;
    a = base;
    foreach (prog[k]) begin
      host_write(a, prog[k]);
      a = a + 32'd4;
    end
  endtask

  task automatic wait_halt(input int limit);
    int n;
    n = 0;
    while (!halted && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!halted) begin
      errors++;
      $display("ERROR: core did not halt within %0d cycles", limit);
    end
  endtask

  task automatic load_arith_program();
    logic [19:0] u1;
    logic [19:0] u2;
    logic [11:0] i1;
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    int k;
    u1 = 20'($urandom);
    u2 = 20'($urandom);
    i1 = 12'($urandom);
    prog.delete();
    prog.push_back(enc_u(u1, 5'd1, OP_LUI));
    prog.push_back(enc_i(i1, 5'd1, F3_ADD, 5'd2, OP_IMM));
    prog.push_back(enc_r(F7_ADD, 5'd2, 5'd1, F3_ADD, 5'd3, OP_REG));
    prog.push_back(enc_r(F7_SUB, 5'd3, 5'd2, F3_ADD, 5'd4, OP_REG));
    // auipc at 0x10
    prog.push_back(enc_u(u2, 5'd5, OP_AUIPC));
    prog.push_back(enc_i(ARITH_BASE[11:0], 5'd0, F3_ADD, 5'd6, OP_IMM));
    // x1..x5 stored in order
    for (k = 1; k <= 5; k++) begin
      prog.push_back(enc_s(12'(4 * (k - 1)), 5'(k), 5'd6, F3_SW, OP_STORE));
    end
    prog.push_back(EBREAK_WORD);
    load_program(32'h0);
    x1 = {u1, 12'h000};
    x2 = x1 + {{20{i1[11]}}, i1};
    x3 = x1 + x2;
    arith_exp[0] = x1;
    arith_exp[1] = x2;
    arith_exp[2] = x3;
    arith_exp[3] = x2 - x3;
    arith_exp[4] = 32'h0000_0010 + {u2, 12'h000};
  endtask

  task automatic check_arith_results();
    logic [31:0] a;
    logic [31:0] d;
    int k;
    for (k = 0; k < 5; k++) begin
      a = ARITH_BASE + 32'(4 * k);
      host_read(a, d);
      check_value("arith result word", arith_exp[k], d);
      mem_model[a[9:2]] = arith_exp[k];
    end
    check_value("trap", 32'h0, 32'(trap));
    // ebreak is word 11
    check_value("pc at ebreak", 32'h2c, pc);
  endtask

  task automatic load_sum_program();
    logic [31:0] a;
    int k;
    sum_exp = '0;
    for (k = 0; k < SUM_N; k++) begin
      a = SUM_BASE + 32'(4 * k);
      host_write(a, $urandom);
      sum_exp = sum_exp + mem_model[a[9:2]];
    end
    prog.delete();
    prog.push_back(enc_i(SUM_BASE[11:0], 5'd0, F3_ADD, 5'd1, OP_IMM));
    prog.push_back(enc_i(12'(SUM_N), 5'd0, F3_ADD, 5'd2, OP_IMM));
    prog.push_back(enc_i(12'd0, 5'd0, F3_ADD, 5'd3, OP_IMM));
    // 0x0c loop head, out to 0x24 once the count is zero
    prog.push_back(enc_b(13'd24, 5'd0, 5'd2, F3_BEQ, OP_BRANCH));
    prog.push_back(enc_i(12'd0, 5'd1, F3_LW, 5'd5, OP_LOAD));
    prog.push_back(enc_r(F7_ADD, 5'd5, 5'd3, F3_ADD, 5'd3, OP_REG));
    prog.push_back(enc_i(12'd4, 5'd1, F3_ADD, 5'd1, OP_IMM));
    prog.push_back(enc_i(12'hfff, 5'd2, F3_ADD, 5'd2, OP_IMM));
    // always taken, back by 20
    prog.push_back(enc_b(13'h1fec, 5'd0, 5'd0, F3_BEQ, OP_BRANCH));
    // sum lands right after the array
    prog.push_back(enc_s(12'd0, 5'd3, 5'd1, F3_SW, OP_STORE));
    prog.push_back(EBREAK_WORD);
    load_program(32'h0);
  endtask

  task automatic check_sum_results();
    logic [31:0] a;
    logic [31:0] d;
    a = SUM_BASE + 32'(4 * SUM_N);
    host_read(a, d);
    check_value("loop sum", sum_exp, d);
    mem_model[a[9:2]] = sum_exp;
    check_value("trap", 32'h0, 32'(trap));
    check_value("pc at ebreak", 32'h28, pc);
  endtask

  task automatic test_host_memory();
    logic [31:0] addrs [0:63];
    logic [31:0] a;
    logic [31:0] d;
    int k;
    for (k = 0; k < 64; k++) begin
      addrs[k] = $urandom;
      host_write(addrs[k], $urandom);
    end
    // same word through other upper bits
    for (k = 0; k < 64; k++) begin
      a = {22'($urandom), addrs[k][9:0]};
      host_read(a, d);
      check_value("host readback", mem_model[addrs[k][9:2]], d);
    end
  endtask

  task automatic test_arith();
    reset_dut();
    load_arith_program();
    start_core();
    wait_halt(HALT_LIMIT);
    check_arith_results();
  endtask

  task automatic test_sum_loop();
    reset_dut();
    load_sum_program();
    start_core();
    wait_halt(HALT_LIMIT);
    check_sum_results();
  endtask

  task automatic test_contention();
    logic [31:0] a;
    logic [31:0] d;
    int n;
    int gap;
    reset_dut();
    // stale sum must not pass
    host_write(SUM_BASE + 32'(4 * SUM_N), 32'h0);
    start_core();
    n = 0;
    while (!halted && n < HALT_LIMIT) begin
      gap = $urandom_range(0, 3);
      repeat (gap) begin
        @(posedge clk);
      end
      // code and array words, never written by the core
      if ($urandom_range(0, 1) == 0) begin
        a = 32'(4 * $urandom_range(0, 10));
      end else begin
        a = SUM_BASE + 32'(4 * $urandom_range(0, SUM_N - 1));
      end
      host_read(a, d);
      check_value("host read under contention", mem_model[a[9:2]], d);
      n++;
    end
    wait_halt(HALT_LIMIT);
    check_sum_results();
  endtask

  task automatic test_illegal();
    logic [31:0] a;
    logic [31:0] d;
    int k;
    reset_dut();
    for (k = 0; k < 32; k++) begin
      a = 32'(4 * k);
      host_write(a, fill_word(a));
    end
    prog.delete();
    prog.push_back(enc_i(12'd5, 5'd0, F3_ADD, 5'd1, OP_IMM));
    prog.push_back(enc_i(12'd7, 5'd1, F3_ADD, 5'd2, OP_IMM));
    // opcode 7'h7f is outside the subset
    prog.push_back(32'hffff_ffff);
    // would hit word 4 if the core ran on
    prog.push_back(enc_s(12'd16, 5'd2, 5'd0, F3_SW, OP_STORE));
    load_program(32'h0);
    start_core();
    wait_halt(HALT_LIMIT);
    check_value("trap", 32'h1, 32'(trap));
    check_value("halted", 32'h1, 32'(halted));
    check_value("pc at illegal word", 32'h8, pc);
    for (k = 3; k < 32; k++) begin
      a = 32'(4 * k);
      host_read(a, d);
      check_value("memory past illegal word", mem_model[a[9:2]], d);
    end
  endtask

  task automatic test_run_gating();
    logic [31:0] a;
    logic [31:0] d;
    int k;
    // halted and trap still up from the illegal run
    reset_dut();
    check_value("halted after reset", 32'h0, 32'(halted));
    check_value("trap after reset", 32'h0, 32'(trap));
    load_arith_program();
    for (k = 0; k < 5; k++) begin
      a = ARITH_BASE + 32'(4 * k);
      host_write(a, fill_word(a));
    end
    // run low, core must sit in idle
    for (k = 0; k < 100; k++) begin
      @(posedge clk);
      check_value("pc with run low", RESET_PC, pc);
    end
    check_value("halted with run low", 32'h0, 32'(halted));
    for (k = 0; k < 5; k++) begin
      a = ARITH_BASE + 32'(4 * k);
      host_read(a, d);
      check_value("store area with run low", mem_model[a[9:2]], d);
    end
    start_core();
    wait_halt(HALT_LIMIT);
    check_arith_results();
  endtask

  initial begin
    rst        = 1'b1;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    void'($urandom(32'h4c3825bb));
    reset_dut();
    test_host_memory();
    test_arith();
    test_sum_loop();
    test_contention();
    test_illegal();
    test_run_gating();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* rv_soc.f */
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_core.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/rv_soc.sv
verification/rv_soc_assert.sv
verification/rv_soc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rv_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module rv_soc_tb -f rv_soc.f \
  --Mdir "$BUILD_DIR" -o rv_soc_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./"$BUILD_DIR"/rv_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0
